// ==== Makefile ====
# Verilator simulation of the d1 data cache
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
SIM       ?= sim_$(TOP)
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only if the run reports success"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR SIM PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
source/dcache_pkg.sv
source/stall_replay_cu.sv
source/d1_ctrl.sv
source/mshr_entry.sv
source/wb_buffer.sv
source/mem_port.sv
source/dcache_top.sv
tests/tb_mem_responder.sv
tests/tb_dcache.sv

// ==== source/d1_ctrl.sv ====
// Decode and data path of the d1 stage
// Tag, data, valid and dirty arrays, replay register, hit and miss responses,
// MSHR allocation, victim push and refill write
`default_nettype none

module d1_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Core side
  input  dcache_pkg::cpu_req_t            cpu_req_i,
  output logic                            cpu_ready_o,
  output dcache_pkg::cpu_rsp_t            hit_rsp_o,
  output dcache_pkg::cpu_rsp_t            miss_rsp_o,
  // Control unit
  input  logic                            replaying_i,
  input  logic                            d1_stalled_i,
  output logic                            lets_stall_o,
  output logic                            lets_replay_o,
  output logic                            lets_wait_wbb_o,
  output logic                            wbb_will_free_o,
  // MSHRs
  input  dcache_pkg::mshr_t               mshr_i [dcache_pkg::NUM_MSHR],
  output logic [dcache_pkg::NUM_MSHR-1:0] alloc_onehot_o,
  output dcache_pkg::mshr_t               alloc_o,
  input  dcache_pkg::refill_t             refill_i,
  // Write-back buffer
  output logic                            wbb_push_o,
  output dcache_pkg::wbb_entry_t          wbb_entry_o,
  input  logic                            wbb_full_i,
  input  logic                            fwd_hit_i,
  input  logic [dcache_pkg::DATA_W-1:0]   fwd_data_i,
  input  logic                            wbb_popped_i
);

  import dcache_pkg::*;

  logic [TAG_W-1:0]     tag_q  [NUM_LINES];
  logic [DATA_W-1:0]    data_q [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q, dirty_q;
  cpu_req_t             rpl_q, req;
  logic [INDEX_W-1:0]   idx, rpl_idx, ref_idx;
  logic [TAG_W-1:0]     tag;
  logic [NUM_MSHR-1:0]  free_onehot;
  logic dec_state, in_stall, act, hit, victim_dirty, fwd;
  logic idx_pend, rpl_pend, all_busy, rpl_clear;
  logic do_hit, do_fwd, do_alloc, do_stall, do_wait;

  // Decode state is neither replay nor any stall
  assign dec_state = !replaying_i && !d1_stalled_i;
  // Full buffer wait never fills the replay register
  assign in_stall  = d1_stalled_i && rpl_q.valid;
  assign req       = replaying_i ? rpl_q : cpu_req_i;
  assign act       = replaying_i ? rpl_q.valid : (dec_state && cpu_req_i.valid);

  assign idx     = req.addr[INDEX_W-1:0];
  assign tag     = req.addr[ADDR_W-1:INDEX_W];
  assign rpl_idx = rpl_q.addr[INDEX_W-1:0];
  assign ref_idx = refill_i.mshr.addr[INDEX_W-1:0];

  assign hit          = valid_q[idx] && (tag_q[idx] == tag);
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  // WBB lookup follows the core address; a replayed request is never in the WBB
  assign fwd          = fwd_hit_i && !replaying_i;

  // Scan MSHRs, descending so the lowest free one wins
  always_comb begin
    idx_pend    = 1'b0;
    rpl_pend    = 1'b0;
    all_busy    = 1'b1;
    free_onehot = '0;
    for (int i = NUM_MSHR - 1; i >= 0; i--) begin
      if (mshr_i[i].busy) begin
        if (mshr_i[i].addr[INDEX_W-1:0] == idx) idx_pend = 1'b1;
        if (mshr_i[i].addr[INDEX_W-1:0] == rpl_idx) rpl_pend = 1'b1;
      end else begin
        all_busy       = 1'b0;
        free_onehot    = '0;
        free_onehot[i] = 1'b1;
      end
    end
  end

  // Priority: hit, pending index, forward, MSHR room, victim room
  always_comb begin
    do_hit   = 1'b0;
    do_fwd   = 1'b0;
    do_alloc = 1'b0;
    do_stall = 1'b0;
    do_wait  = 1'b0;
    if (act) begin
      if (hit) begin
        do_hit = 1'b1;
      end else if (idx_pend || (!fwd && all_busy)) begin
        do_stall = 1'b1;
      end else if (victim_dirty && wbb_full_i) begin
        do_wait = 1'b1;
      end else if (fwd) begin
        do_fwd = 1'b1;
      end else begin
        do_alloc = 1'b1;
      end
    end
  end

  // Leave stall once an MSHR and the index are free, with room for a victim
  // The WBB only drains while stalled, so not full now means room at replay
  assign rpl_clear = in_stall && !wbb_full_i &&
                     ((refill_i.valid && (!rpl_pend || ref_idx == rpl_idx)) ||
                      (!all_busy && !rpl_pend));

  assign lets_stall_o    = dec_state && do_stall;
  assign lets_wait_wbb_o = dec_state && do_wait;
  assign lets_replay_o   = (dec_state && do_fwd) || rpl_clear;
  assign wbb_will_free_o = wbb_popped_i;
  assign cpu_ready_o     = dec_state && !lets_wait_wbb_o;

  // Victim goes out on allocation, or when a forwarded line replaces it
  assign wbb_push_o       = (do_alloc || do_fwd) && victim_dirty;
  assign wbb_entry_o.addr = {tag_q[idx], idx};
  assign wbb_entry_o.data = data_q[idx];

  assign alloc_onehot_o = do_alloc ? free_onehot : '0;
  assign alloc_o.busy   = 1'b1;
  assign alloc_o.issued = 1'b0;
  assign alloc_o.addr   = req.addr;
  assign alloc_o.we     = req.we;
  assign alloc_o.wdata  = req.wdata;
  assign alloc_o.id     = req.id;

  // Refill index never collides with a decode write
  always_ff @(posedge clk_i) begin
    if (refill_i.valid) begin
      tag_q[ref_idx]  <= refill_i.mshr.addr[ADDR_W-1:INDEX_W];
      data_q[ref_idx] <= refill_i.mshr.we ? refill_i.mshr.wdata : refill_i.data;
    end
    if (do_fwd) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= fwd_data_i;
    end else if (do_hit && req.we) begin
      data_q[idx] <= req.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      dirty_q    <= '0;
      rpl_q      <= '0;
      hit_rsp_o  <= '0;
      miss_rsp_o <= '0;
    end else begin
      if (refill_i.valid) begin
        valid_q[ref_idx] <= 1'b1;
        dirty_q[ref_idx] <= refill_i.mshr.we;
      end
      if (do_fwd) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b1;
      end else if (do_alloc) begin
        valid_q[idx] <= 1'b0;
        dirty_q[idx] <= 1'b0;
      end else if (do_hit && req.we) begin
        dirty_q[idx] <= 1'b1;
      end
      // Capture stalled or forwarded requests, drop after the replay
      if (dec_state && (do_stall || do_fwd)) begin
        rpl_q <= cpu_req_i;
      end else if (replaying_i) begin
        rpl_q.valid <= 1'b0;
      end
      hit_rsp_o.valid  <= do_hit;
      hit_rsp_o.id     <= req.id;
      hit_rsp_o.rdata  <= req.we ? '0 : data_q[idx];
      miss_rsp_o.valid <= refill_i.valid;
      miss_rsp_o.id    <= refill_i.mshr.id;
      miss_rsp_o.rdata <= refill_i.mshr.we ? '0 : refill_i.data;
    end
  end

  a_lets_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({lets_stall_o, lets_replay_o, lets_wait_wbb_o}));

  // The stall exit condition guarantees the replayed decode completes
  a_replay_no_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    replaying_i |-> !(do_stall || do_wait || do_fwd));

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
// Sizes and shared types of the d1 data cache
// Core request and response, MSHR, write-back buffer, memory command and refill
`default_nettype none

package dcache_pkg;

  // Geometry: direct mapped, one word per line
  localparam int ADDR_W    = 16;
  localparam int INDEX_W   = 3;
  localparam int NUM_LINES = 8;
  localparam int TAG_W     = ADDR_W - INDEX_W;
  localparam int DATA_W    = 32;
  localparam int ID_W      = 4;
  // Miss and eviction resources
  localparam int NUM_MSHR  = 2;
  localparam int WBB_DEPTH = 2;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [ID_W-1:0]   id;
  } cpu_req_t;

  // Read data is zero for stores
  typedef struct packed {
    logic              valid;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic              busy;
    logic              issued;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [ID_W-1:0]   id;
  } mshr_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } wbb_entry_t;

  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_cmd_t;

  // Miss that got its memory data back
  typedef struct packed {
    logic              valid;
    mshr_t             mshr;
    logic [DATA_W-1:0] data;
  } refill_t;

endpackage

`default_nettype wire

// ==== source/dcache_top.sv ====
// Top level of the d1 data cache
// Decode, control unit, MSHR entries, write-back buffer and memory port
`default_nettype none

module dcache_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  dcache_pkg::cpu_req_t          cpu_req_i,
  output logic                          cpu_ready_o,
  output dcache_pkg::cpu_rsp_t          hit_rsp_o,
  output dcache_pkg::cpu_rsp_t          miss_rsp_o,
  output logic                          mem_req_o,
  output dcache_pkg::mem_cmd_t          mem_cmd_o,
  input  logic                          mem_ack_i,
  input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i
);

  import dcache_pkg::*;

  logic                lets_stall, lets_replay, lets_wait_wbb, wbb_will_free;
  logic                replaying, d1_stalled;
  mshr_t               mshr [NUM_MSHR];
  mshr_t               alloc;
  logic [NUM_MSHR-1:0] alloc_onehot, issue_onehot, complete_onehot;
  refill_t             refill;
  logic                wbb_push, wbb_full, wbb_empty, wbb_pop, fwd_hit;
  wbb_entry_t          wbb_entry, wbb_head;
  logic [DATA_W-1:0]   fwd_data;

  d1_ctrl u_d1_ctrl (
    .clk_i, .rst_ni, .cpu_req_i, .cpu_ready_o, .hit_rsp_o, .miss_rsp_o,
    .replaying_i     (replaying),
    .d1_stalled_i    (d1_stalled),
    .lets_stall_o    (lets_stall),
    .lets_replay_o   (lets_replay),
    .lets_wait_wbb_o (lets_wait_wbb),
    .wbb_will_free_o (wbb_will_free),
    .mshr_i          (mshr),
    .alloc_onehot_o  (alloc_onehot),
    .alloc_o         (alloc),
    .refill_i        (refill),
    .wbb_push_o      (wbb_push),
    .wbb_entry_o     (wbb_entry),
    .wbb_full_i      (wbb_full),
    .fwd_hit_i       (fwd_hit),
    .fwd_data_i      (fwd_data),
    .wbb_popped_i    (wbb_pop)
  );

  stall_replay_cu u_cu (
    .clk_i, .rst_ni,
    .lets_stall_i    (lets_stall),
    .lets_replay_i   (lets_replay),
    .lets_wait_wbb_i (lets_wait_wbb),
    .wbb_will_free_i (wbb_will_free),
    .replaying_o     (replaying),
    .d1_stalled_o    (d1_stalled)
  );

  // One entry per outstanding miss
  for (genvar g = 0; g < NUM_MSHR; g++) begin : g_mshr
    mshr_entry u_mshr (
      .clk_i, .rst_ni,
      .alloc_i      (alloc_onehot[g]),
      .alloc_data_i (alloc),
      .issue_i      (issue_onehot[g]),
      .complete_i   (complete_onehot[g]),
      .entry_o      (mshr[g])
    );
  end

  // Forwarding only matters for requests decoded from the core port
  wb_buffer u_wbb (
    .clk_i, .rst_ni,
    .push_i        (wbb_push),
    .push_entry_i  (wbb_entry),
    .pop_i         (wbb_pop),
    .head_o        (wbb_head),
    .empty_o       (wbb_empty),
    .full_o        (wbb_full),
    .lookup_addr_i (cpu_req_i.addr),
    .fwd_hit_o     (fwd_hit),
    .fwd_data_o    (fwd_data)
  );

  mem_port u_mem_port (
    .clk_i, .rst_ni, .mem_req_o, .mem_cmd_o, .mem_ack_i, .mem_rdata_i,
    .wbb_head_i        (wbb_head),
    .wbb_empty_i       (wbb_empty),
    .wbb_pop_o         (wbb_pop),
    .mshr_i            (mshr),
    .issue_onehot_o    (issue_onehot),
    .complete_onehot_o (complete_onehot),
    .refill_o          (refill)
  );

endmodule

`default_nettype wire

// ==== source/mem_port.sv ====
// Four-phase memory master
// Drains the write-back buffer first, then the lowest pending MSHR read,
// and hands completed reads back as refills
`default_nettype none

module mem_port (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Memory side
  output logic                            mem_req_o,
  output dcache_pkg::mem_cmd_t            mem_cmd_o,
  input  logic                            mem_ack_i,
  input  logic [dcache_pkg::DATA_W-1:0]   mem_rdata_i,
  // Write-back buffer head
  input  dcache_pkg::wbb_entry_t          wbb_head_i,
  input  logic                            wbb_empty_i,
  output logic                            wbb_pop_o,
  // MSHRs
  input  dcache_pkg::mshr_t               mshr_i [dcache_pkg::NUM_MSHR],
  output logic [dcache_pkg::NUM_MSHR-1:0] issue_onehot_o,
  output logic [dcache_pkg::NUM_MSHR-1:0] complete_onehot_o,
  output dcache_pkg::refill_t             refill_o
);

  import dcache_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StRequest,
    StRelease
  } state_t;

  state_t              state_q, state_d;
  logic                is_wb_q;
  logic [NUM_MSHR-1:0] sel_q, pick;
  logic [ADDR_W-1:0]   pick_addr;
  mem_cmd_t            cmd_q;
  mshr_t               sel_entry;

  // Lowest busy MSHR whose read is not yet sent
  always_comb begin
    pick      = '0;
    pick_addr = '0;
    for (int i = NUM_MSHR - 1; i >= 0; i--) begin
      if (mshr_i[i].busy && !mshr_i[i].issued) begin
        pick      = '0;
        pick[i]   = 1'b1;
        pick_addr = mshr_i[i].addr;
      end
    end
  end

  // Entry being served
  always_comb begin
    sel_entry = '0;
    for (int i = 0; i < NUM_MSHR; i++) begin
      if (sel_q[i]) sel_entry = mshr_i[i];
    end
  end

  always_comb begin
    state_d           = state_q;
    issue_onehot_o    = '0;
    complete_onehot_o = '0;
    wbb_pop_o         = 1'b0;
    refill_o.valid    = 1'b0;
    refill_o.mshr     = sel_entry;
    refill_o.data     = mem_rdata_i;
    case (state_q)
      StIdle: begin
        if (!wbb_empty_i) begin
          state_d = StRequest;
        end else if (|pick) begin
          state_d        = StRequest;
          issue_onehot_o = pick;
        end
      end
      // Ack seen once per transfer, data valid with it
      StRequest: begin
        if (mem_ack_i) begin
          state_d = StRelease;
          if (is_wb_q) begin
            wbb_pop_o = 1'b1;
          end else begin
            complete_onehot_o = sel_q;
            refill_o.valid    = 1'b1;
          end
        end
      end
      // Req dropped, wait for the slave to drop ack
      StRelease: begin
        if (!mem_ack_i) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  // Command loaded in idle and held through the transfer
  always_ff @(posedge clk_i) begin
    if (state_q == StIdle) begin
      cmd_q.we    <= !wbb_empty_i;
      cmd_q.addr  <= wbb_empty_i ? pick_addr : wbb_head_i.addr;
      cmd_q.wdata <= wbb_empty_i ? '0 : wbb_head_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StIdle;
      is_wb_q <= 1'b0;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == StIdle) begin
        is_wb_q <= !wbb_empty_i;
        sel_q   <= wbb_empty_i ? pick : '0;
      end
    end
  end

  assign mem_req_o = (state_q == StRequest);
  assign mem_cmd_o = cmd_q;

  a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(mem_req_o) && mem_req_o |-> $stable(mem_cmd_o));

endmodule

`default_nettype wire

// ==== source/mshr_entry.sv ====
// Single miss-status holding register
// Busy from allocation to completion, issued once its read is sent
`default_nettype none

module mshr_entry (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              alloc_i,
  input  dcache_pkg::mshr_t alloc_data_i,
  input  logic              issue_i,
  input  logic              complete_i,
  output dcache_pkg::mshr_t entry_o
);

  import dcache_pkg::*;

  mshr_t entry_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
    end else if (alloc_i) begin
      // Allocation data arrives already marked busy
      entry_q <= alloc_data_i;
    end else if (complete_i) begin
      entry_q.busy   <= 1'b0;
      entry_q.issued <= 1'b0;
    end else if (issue_i) begin
      entry_q.issued <= 1'b1;
    end
  end

  assign entry_o = entry_q;

  a_no_alloc_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_i |-> !entry_q.busy);

endmodule

`default_nettype wire

// ==== source/stall_replay_cu.sv ====
// Stall and replay control unit of the d1 stage
// Four-state FSM: decode, stall, replay, wait on full write-back buffer
`default_nettype none

module stall_replay_cu (
  input  logic clk_i,
  input  logic rst_ni,
  // Requests from d1_ctrl, acted upon in the next cycle
  input  logic lets_stall_i,
  input  logic lets_replay_i,
  input  logic lets_wait_wbb_i,
  input  logic wbb_will_free_i,
  // Decoded from the state register
  output logic replaying_o,
  output logic d1_stalled_o
);

  typedef enum logic [1:0] {
    StDecode,
    StStall,
    StReplay,
    StFullBuffer
  } state_t;

  state_t state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Stall has priority over a forwarding replay, then the WBB wait
      StDecode: begin
        if (lets_stall_i) begin
          state_d = StStall;
        end else if (lets_replay_i) begin
          state_d = StReplay;
        end else if (lets_wait_wbb_i) begin
          state_d = StFullBuffer;
        end
      end
      // Replay register full, waiting for a refill
      StStall: begin
        if (lets_replay_i) begin
          state_d = StReplay;
        end
      end
      // Single cycle, the replay register is decoded
      StReplay: state_d = StDecode;
      // Core request held outside until a writeback completes
      StFullBuffer: begin
        if (wbb_will_free_i) begin
          state_d = StDecode;
        end
      end
      default: state_d = StDecode;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StDecode;
    end else begin
      state_q <= state_d;
    end
  end

  assign replaying_o  = (state_q == StReplay);
  assign d1_stalled_o = (state_q == StStall) || (state_q == StFullBuffer);

  // New stall or wait requests only come from a decode of the core port
  a_no_stall_outside_decode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (replaying_o || d1_stalled_o) |-> !(lets_stall_i || lets_wait_wbb_i));

endmodule

`default_nettype wire

// ==== source/wb_buffer.sv ====
// Write-back buffer for dirty victims
// Circular FIFO with a youngest-first address lookup for forwarding
`default_nettype none

module wb_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  dcache_pkg::wbb_entry_t        push_entry_i,
  input  logic                          pop_i,
  output dcache_pkg::wbb_entry_t        head_o,
  output logic                          empty_o,
  output logic                          full_o,
  input  logic [dcache_pkg::ADDR_W-1:0] lookup_addr_i,
  output logic                          fwd_hit_o,
  output logic [dcache_pkg::DATA_W-1:0] fwd_data_o
);

  import dcache_pkg::*;

  wbb_entry_t                     mem_q [WBB_DEPTH];
  logic [$clog2(WBB_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q, pos;
  logic [$clog2(WBB_DEPTH+1)-1:0] count_q;

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == WBB_DEPTH);

  // Walk from oldest to youngest, a later match overrides
  always_comb begin
    fwd_hit_o  = 1'b0;
    fwd_data_o = '0;
    pos        = rd_ptr_q;
    for (int i = 0; i < WBB_DEPTH; i++) begin
      if (i < int'(count_q) && mem_q[pos].addr == lookup_addr_i) begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = mem_q[pos].data;
      end
      pos = pos + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && full_o |-> pop_i);

endmodule

`default_nettype wire

// ==== tests/tb_dcache.sv ====
// Testbench top for the d1 data cache
// Clock, reset, directed and LCG stimulus, reference model, response checker, report
`default_nettype none

module tb_dcache;
  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  localparam int TIMEOUT = 1000;

  logic              clk = 1'b0;
  logic              rst_n;
  cpu_req_t          cpu_req;
  logic              cpu_ready;
  cpu_rsp_t          hit_rsp, miss_rsp;
  logic              mem_req, mem_ack;
  mem_cmd_t          mem_cmd;
  logic [DATA_W-1:0] mem_rdata;

  // Reference state
  logic [DATA_W-1:0]  shadow [2**ADDR_W];
  logic [DATA_W-1:0]  expect_data [2**ID_W];
  logic [2**ID_W-1:0] pending;
  logic [ID_W-1:0]    next_id;
  logic [31:0]        rng;
  // Memory command log, {we, addr} at each req rise
  logic [ADDR_W:0]    mem_log [$];
  logic               mem_req_d;
  int                 quiet_cycles;
  int err_count, check_count, hit_count, miss_count;
  bit timed_out = 1'b0;

  always #2 clk = ~clk;

  dcache_top u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .cpu_req_i   (cpu_req),
    .cpu_ready_o (cpu_ready),
    .hit_rsp_o   (hit_rsp),
    .miss_rsp_o  (miss_rsp),
    .mem_req_o   (mem_req),
    .mem_cmd_o   (mem_cmd),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  tb_mem_responder u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mem_req_i   (mem_req),
    .mem_cmd_i   (mem_cmd),
    .mem_ack_o   (mem_ack),
    .mem_rdata_o (mem_rdata)
  );

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // Same address-based fill as the memory model starts with
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a ^ 16'hc35a, a + 16'h1234};
  endfunction

  // Applies one access in program order, returns the expected read data
  function automatic logic [DATA_W-1:0] ref_access(input logic we,
                                                   input logic [ADDR_W-1:0] a,
                                                   input logic [DATA_W-1:0] d);
    if (we) begin
      shadow[a] = d;
      return '0;
    end
    return shadow[a];
  endfunction

  task automatic flag_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    err_count++;
  endtask

  task automatic flag_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    timed_out = 1'b1;
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  task automatic check_rsp(input cpu_rsp_t rsp, input bit from_hit);
    check_count++;
    if (!pending[rsp.id]) begin
      flag_error($sformatf("response for id %0d which is not outstanding", rsp.id));
    end else if (rsp.rdata !== expect_data[rsp.id]) begin
      flag_error($sformatf("id %0d returned %08h, expected %08h",
                           rsp.id, rsp.rdata, expect_data[rsp.id]));
    end
    pending[rsp.id] = 1'b0;
    if (from_hit) hit_count++;
    else miss_count++;
  endtask

  // Checker and memory monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (hit_rsp.valid) check_rsp(hit_rsp, 1'b1);
      if (miss_rsp.valid) check_rsp(miss_rsp, 1'b0);
      if (mem_req && !mem_req_d) mem_log.push_back({mem_cmd.we, mem_cmd.addr});
      mem_req_d    = mem_req;
      quiet_cycles = mem_req ? 0 : quiet_cycles + 1;
    end
  end

  // Starts and ends on a rising edge; returns right after acceptance
  task automatic issue_request(input logic we, input logic [ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
    int n;
    n = 0;
    while (pending[next_id] && !timed_out) begin
      @(negedge clk);
      cpu_req.valid = 1'b0;
      @(posedge clk);
      n++;
      if (n > TIMEOUT) flag_timeout("a free request id");
    end
    @(negedge clk);
    cpu_req.valid = 1'b1;
    cpu_req.we    = we;
    cpu_req.addr  = addr;
    cpu_req.wdata = wdata;
    cpu_req.id    = next_id;
    n = 0;
    #1;
    while (!cpu_ready && !timed_out) begin
      @(negedge clk);
      #1;
      n++;
      if (n > TIMEOUT) flag_timeout("cpu_ready_o");
    end
    expect_data[next_id] = ref_access(we, addr, wdata);
    pending[next_id]     = 1'b1;
    next_id++;
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      cpu_req.valid = 1'b0;
      @(posedge clk);
    end
  endtask

  // All responses in and the memory port quiet, so the WBB is empty
  task automatic wait_drain();
    int n;
    n = 0;
    idle_cycles(1);
    while ((pending != '0 || quiet_cycles < 8) && !timed_out) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) flag_timeout("outstanding responses and an idle memory port");
    end
  endtask

  initial begin
    wait (timed_out);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int errs, hits0, mark;
    logic [31:0] r;
    bit seen_write;
    rng          = 32'h3981f526;
    cpu_req      = '0;
    rst_n        = 1'b0;
    pending      = '0;
    next_id      = '0;
    mem_req_d    = 1'b0;
    quiet_cycles = 0;
    err_count    = 0;
    check_count  = 0;
    hit_count    = 0;
    miss_count   = 0;
    for (int i = 0; i < 2**ADDR_W; i++) begin
      shadow[i] = fill_word(16'(i));
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs right after reset
    errs = err_count;
    @(negedge clk);
    if (!cpu_ready || hit_rsp.valid || miss_rsp.valid || mem_req) begin
      flag_error("outputs not idle after reset");
    end
    @(posedge clk);
    report_test("1 reset state", errs);

    // Store misses fill the lines, then stores and loads must hit
    errs = err_count;
    for (int i = 0; i < 4; i++) issue_request(1'b1, 16'h0010 + 16'(i), lcg_next());
    wait_drain();
    hits0 = hit_count;
    for (int i = 0; i < 4; i++) issue_request(1'b1, 16'h0010 + 16'(i), lcg_next());
    for (int i = 0; i < 4; i++) issue_request(1'b0, 16'h0010 + 16'(i), '0);
    wait_drain();
    if (hit_count - hits0 != 8) flag_error("accesses to cached lines did not all hit");
    report_test("2 store and load hits", errs);

    // Third back-to-back miss finds both MSHRs busy
    errs = err_count;
    issue_request(1'b0, 16'h1004, '0);
    issue_request(1'b0, 16'h1005, '0);
    issue_request(1'b0, 16'h1006, '0);
    @(negedge clk);
    cpu_req.valid = 1'b0;
    if (cpu_ready) flag_error("third miss did not stall the core port");
    @(posedge clk);
    wait_drain();
    report_test("3 stall on busy MSHRs", errs);

    // Dirty lines evicted by conflicting loads, then read back
    errs = err_count;
    for (int i = 0; i < 8; i++) issue_request(1'b1, 16'h0040 + 16'(i), lcg_next());
    wait_drain();
    for (int i = 0; i < 8; i++) issue_request(1'b0, 16'h0080 + 16'(i), '0);
    wait_drain();
    for (int i = 0; i < 8; i++) begin
      if (u_mem.mem_q[16'h0040 + i] !== shadow[16'h0040 + i]) begin
        flag_error($sformatf("victim %04h written back wrong", 16'h0040 + i));
      end
    end
    for (int i = 0; i < 8; i++) issue_request(1'b0, 16'h0040 + 16'(i), '0);
    wait_drain();
    report_test("4 victim writeback", errs);

    // Load of a victim right after its eviction
    errs = err_count;
    issue_request(1'b1, 16'h0307, lcg_next());
    wait_drain();
    mark = mem_log.size();
    issue_request(1'b0, 16'h0507, '0);
    issue_request(1'b0, 16'h0307, '0);
    wait_drain();
    seen_write = 1'b0;
    for (int i = mark; i < mem_log.size(); i++) begin
      if (mem_log[i][ADDR_W-1:0] == 16'h0307) begin
        if (!mem_log[i][ADDR_W] && !seen_write) flag_error("read of 0307 before its writeback");
        if (mem_log[i][ADDR_W]) seen_write = 1'b1;
      end
    end
    if (!seen_write) flag_error("victim 0307 never written back");
    report_test("5 load of an evicted line", errs);

    // Random mix over 32 addresses, 4 tags per index
    errs = err_count;
    for (int i = 0; i < 400; i++) begin
      r = lcg_next();
      issue_request(r[26], 16'h0200 + 16'(r[31:27]), lcg_next());
      if (r[25:24] == 2'b00) idle_cycles(int'(r[23:22]) + 1);
    end
    wait_drain();
    report_test("6 random operations", errs);

    if (pending != '0) flag_error("ids left without a response");
    $display("Checks %0d, hits %0d, misses %0d, leftover ids %0d, errors %0d",
             check_count, hit_count, miss_count, $countones(pending), err_count);
    if (err_count == 0 && !timed_out) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_mem_responder.sv ====
// Four-phase memory slave for the d1 cache testbench
// Word array with an address-based fill and a random ack delay
`default_nettype none

module tb_mem_responder (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          mem_req_i,
  input  dcache_pkg::mem_cmd_t          mem_cmd_i,
  output logic                          mem_ack_o,
  output logic [dcache_pkg::DATA_W-1:0] mem_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import dcache_pkg::*;

  logic [DATA_W-1:0] mem_q [2**ADDR_W];
  logic              ack_q = 1'b0;
  logic [DATA_W-1:0] rdata_q = '0;
  logic [31:0]       rng = 32'h3981f526;
  logic              counting = 1'b0;
  int                wait_left = 0;

  // Every word differs, built from the whole address
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return {a ^ 16'hc35a, a + 16'h1234};
  endfunction

  // LCG step, top bits give 1 to 4 cycles
  function automatic int pick_delay();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return 1 + int'(rng[31:30]);
  endfunction

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem_q[i] = fill_word(16'(i));
    end
  end

  assign mem_ack_o   = ack_q;
  assign mem_rdata_o = rdata_q;

  // Driven on the falling edge, the master samples on the rising one
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      counting <= 1'b0;
    end else if (mem_req_i && !ack_q) begin
      if (!counting) begin
        counting  <= 1'b1;
        wait_left <= pick_delay();
      end else if (wait_left > 1) begin
        wait_left <= wait_left - 1;
      end else begin
        // Write lands when acked, read data held while ack is high
        counting <= 1'b0;
        ack_q    <= 1'b1;
        if (mem_cmd_i.we) begin
          mem_q[mem_cmd_i.addr] <= mem_cmd_i.wdata;
          rdata_q               <= '0;
        end else begin
          rdata_q <= mem_q[mem_cmd_i.addr];
        end
      end
    end else if (ack_q && !mem_req_i) begin
      ack_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire
